// File: audio_pkg.sv
/*
 * Audio back end shared definitions
 * Widths, sample divider, fixed-point filter coefficients and the
 * enums used by the filter sequencer and datapath
 */
package audio_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and rates
	//////////////////////////////////////////////////////////////////////

	// Clocks per audio sample, about 46.9 kHz from the system clock
	localparam int SAMPLE_DIV = 256;
	localparam int DIV_BITS   = $clog2(SAMPLE_DIV);

	// Raw sound DAC width and the boxcar sum that holds one full period
	localparam int DAC_W      = 8;
	localparam int BOXCAR_W   = DAC_W + DIV_BITS;

	localparam int SAMPLE_W    = 16;
	localparam int COEFF_W     = 18;
	localparam int ACC_W       = 40;
	// Fraction bits of every coefficient
	localparam int COEFF_SCALE = 15;

	// Signed 16-bit saturation limits
	localparam int SAMPLE_MAX = 32767;
	localparam int SAMPLE_MIN = -32768;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [COEFF_W-1:0]  coeff_t;
	typedef logic signed [ACC_W-1:0]    acc_t;

	//////////////////////////////////////////////////////////////////////
	// Filter coefficients, Q15
	//////////////////////////////////////////////////////////////////////

	// DAC first-order low-pass, about 12 kHz corner
	localparam coeff_t DAC_B1 = 18'sd16693;
	localparam coeff_t DAC_B2 = 18'sd16693;
	localparam coeff_t DAC_A2 = 18'sd618;

	// Speech op-amp stage 1, f0 near 3.47 kHz
	localparam coeff_t SP1_B1 = 18'sd1318;
	localparam coeff_t SP1_B2 = 18'sd2636;
	localparam coeff_t SP1_B3 = 18'sd1318;
	localparam coeff_t SP1_A2 = -18'sd44251;
	localparam coeff_t SP1_A3 = 18'sd16754;

	// Speech op-amp stage 2, f0 near 3.33 kHz
	localparam coeff_t SP2_B1 = 18'sd1226;
	localparam coeff_t SP2_B2 = 18'sd2453;
	localparam coeff_t SP2_B3 = 18'sd1226;
	localparam coeff_t SP2_A2 = -18'sd45163;
	localparam coeff_t SP2_A3 = 18'sd17301;

	// Filter sections, also the datapath opcode
	typedef enum logic [1:0] {
		SEC_DAC,
		SEC_SPEECH1,
		SEC_SPEECH2
	} section_t;

	// Products per section, indexed by section_t
	localparam logic [2:0][2:0] SECTION_TAPS = {3'd5, 3'd5, 3'd3};

	typedef enum logic [1:0] {
		IDLE,
		MAC,
		WRITE
	} seq_state_t;

endpackage

// File: sample_timer.sv
/*
 * Sample timer
 * Free-running divider that issues a one-cycle tick per audio sample
 */
`timescale 1ns/1ps

module sample_timer (
	input  logic clk_sys,
	input  logic reset,
	output logic tick
);
	import audio_pkg::*;

	// Position inside the current sample period
	logic [DIV_BITS-1:0] count;

	// Counter wraps by itself at SAMPLE_DIV
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// Last clock of the period
	// First one lands SAMPLE_DIV clocks after reset drops
	assign tick = (count == DIV_BITS'(SAMPLE_DIV - 1));

endmodule

// File: dac_boxcar.sv
/*
 * DAC boxcar averager
 * Sums the raw 8-bit sound DAC over one sample period and
 * presents the mean at each tick
 */
`timescale 1ns/1ps

module dac_boxcar (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       tick,
	input  logic [audio_pkg::DAC_W-1:0] dac_in,
	output logic [audio_pkg::DAC_W-1:0] dac_avg
);
	import audio_pkg::*;

	// Running sum of this period
	logic [BOXCAR_W-1:0] accum;
	// Sum including the sample on the current clock
	logic [BOXCAR_W-1:0] sum_now;

	// 256 samples of 255 still fit in 16 bits
	assign sum_now = accum + BOXCAR_W'(dac_in);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			accum   <= '0;
			dac_avg <= '0;
		end else if (tick) begin
			// Divide by SAMPLE_DIV, start the next period empty
			dac_avg <= sum_now[BOXCAR_W-1:DIV_BITS];
			accum   <= '0;
		end else begin
			accum <= sum_now;
		end
	end

endmodule

// File: filter_sequencer.sv
/*
 * Filter sequencer
 * Steps the shared MAC datapath through the DAC section and the two
 * speech sections, one tap per clock and one write per section
 */
`timescale 1ns/1ps

module filter_sequencer (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                tick,
	output audio_pkg::section_t section,
	output logic [2:0]          tap,
	output logic                acc_clear,
	output logic                acc_en,
	output logic                write_en,
	output logic                done
);
	import audio_pkg::*;

	seq_state_t state;

	// Final product of the current section
	logic last_tap;
	// Speech stage 2 closes the sample
	logic last_section;

	assign last_tap     = (tap == SECTION_TAPS[section] - 3'd1);
	assign last_section = (section == SEC_SPEECH2);

	//////////////////////////////////////////////////////////////////////
	// State machine
	//////////////////////////////////////////////////////////////////////

	// One pass per tick: 4 + 6 + 6 clocks, done one clock after the last write
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= IDLE;
			section <= SEC_DAC;
			tap     <= '0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: begin
					// Start with the DAC section on the clock after tick
					if (tick) begin
						state   <= MAC;
						section <= SEC_DAC;
						tap     <= '0;
					end
				end
				MAC: begin
					if (last_tap) begin
						state <= WRITE;
					end else begin
						tap <= tap + 3'd1;
					end
				end
				WRITE: begin
					tap <= '0;
					if (last_section) begin
						// Histories now hold the new outputs
						state <= IDLE;
						done  <= 1'b1;
					end else begin
						section <= section_t'(section + 2'd1);
						state   <= MAC;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Datapath controls
	//////////////////////////////////////////////////////////////////////

	assign acc_en    = (state == MAC);
	// First product of a section replaces the old sum
	assign acc_clear = (state == MAC) && (tap == 3'd0);
	assign write_en  = (state == WRITE);

endmodule

// File: filter_datapath.sv
/*
 * Shared filter datapath
 * One signed multiplier and 40-bit accumulator serve all three
 * direct form I sections, each with its own x and y history
 */
`timescale 1ns/1ps

module filter_datapath (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic [audio_pkg::DAC_W-1:0]    dac_avg,
	input  logic [audio_pkg::SAMPLE_W-1:0] speech_in,
	input  logic                        tick,
	input  audio_pkg::section_t         section,
	input  logic [2:0]                  tap,
	input  logic                        acc_clear,
	input  logic                        acc_en,
	input  logic                        write_en,
	output audio_pkg::sample_t          dac_filt,
	output audio_pkg::sample_t          speech_filt
);
	import audio_pkg::*;

	// Per-section history, DAC uses only x1 and y1
	sample_t hist_x1 [3];
	sample_t hist_x2 [3];
	sample_t hist_y1 [3];
	sample_t hist_y2 [3];

	sample_t dac_x;
	sample_t speech_x;
	sample_t x_cur;
	sample_t operand;
	coeff_t  coef;
	logic signed [SAMPLE_W+COEFF_W-1:0] product;
	acc_t    acc;
	acc_t    acc_shift;
	sample_t y_new;

	// Unsigned boxcar mean to signed 16 bits around midscale
	assign dac_x = {dac_avg, 8'h00} - 16'h8000;

	// Speech held for the whole pass, valid from the clock after tick
	always_ff @(posedge clk_sys) begin
		if (tick) begin
			speech_x <= speech_in - 16'h8000;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Operand and coefficient select
	//////////////////////////////////////////////////////////////////////

	// Stage 2 reads stage 1 output straight from its history
	always_comb begin
		case (section)
			SEC_DAC:     x_cur = dac_x;
			SEC_SPEECH1: x_cur = speech_x;
			default:     x_cur = hist_y1[SEC_SPEECH1];
		endcase
	end

	// Tap order is B1 x, B2 x1, B3 x2, then feedback with negated A terms
	always_comb begin
		case (tap)
			3'd0:    operand = x_cur;
			3'd1:    operand = hist_x1[section];
			3'd2:    operand = (section == SEC_DAC) ? hist_y1[section] : hist_x2[section];
			3'd3:    operand = hist_y1[section];
			default: operand = hist_y2[section];
		endcase
	end

	always_comb begin
		coef = '0;
		case (section)
			SEC_DAC: begin
				case (tap)
					3'd0:    coef = DAC_B1;
					3'd1:    coef = DAC_B2;
					default: coef = -DAC_A2;
				endcase
			end
			SEC_SPEECH1: begin
				case (tap)
					3'd0:    coef = SP1_B1;
					3'd1:    coef = SP1_B2;
					3'd2:    coef = SP1_B3;
					3'd3:    coef = -SP1_A2;
					default: coef = -SP1_A3;
				endcase
			end
			default: begin
				case (tap)
					3'd0:    coef = SP2_B1;
					3'd1:    coef = SP2_B2;
					3'd2:    coef = SP2_B3;
					3'd3:    coef = -SP2_A2;
					default: coef = -SP2_A3;
				endcase
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Multiply, accumulate, saturate
	//////////////////////////////////////////////////////////////////////

	assign product   = operand * coef;
	assign acc_shift = acc >>> COEFF_SCALE;

	always_comb begin
		if (acc_shift > SAMPLE_MAX) begin
			y_new = sample_t'(SAMPLE_MAX);
		end else if (acc_shift < SAMPLE_MIN) begin
			y_new = sample_t'(SAMPLE_MIN);
		end else begin
			y_new = acc_shift[SAMPLE_W-1:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc <= '0;
			for (int i = 0; i < 3; i++) begin
				hist_x1[i] <= '0;
				hist_x2[i] <= '0;
				hist_y1[i] <= '0;
				hist_y2[i] <= '0;
			end
		end else begin
			if (acc_en) begin
				acc <= (acc_clear ? '0 : acc) + acc_t'(product);
			end
			// Shift the delay lines of the section just finished
			if (write_en) begin
				hist_x2[section] <= hist_x1[section];
				hist_x1[section] <= x_cur;
				hist_y2[section] <= hist_y1[section];
				hist_y1[section] <= y_new;
			end
		end
	end

	assign dac_filt    = hist_y1[SEC_DAC];
	assign speech_filt = hist_y1[SEC_SPEECH2];

endmodule

// File: audio_mixer.sv
/*
 * Audio mixer
 * Speech gain of four with saturation, offset conversion and the
 * final unsigned mix, registered once per sample
 */
`timescale 1ns/1ps

module audio_mixer (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        done,
	input  logic [audio_pkg::SAMPLE_W-1:0] speech_in,
	input  logic                        speech_filter_en,
	input  audio_pkg::sample_t          dac_filt,
	input  audio_pkg::sample_t          speech_filt,
	output logic [audio_pkg::SAMPLE_W-1:0] audio_out,
	output logic                        sample_valid
);
	import audio_pkg::*;

	logic signed [SAMPLE_W+1:0] boosted;
	sample_t                    speech_gain;
	logic [SAMPLE_W-1:0]        speech_term;
	logic [SAMPLE_W-1:0]        dac_term;
	logic [SAMPLE_W:0]          mix_sum;

	// Output stage boost, shift by two for a clean x4
	assign boosted = {speech_filt, 2'b00};

	always_comb begin
		if (boosted > SAMPLE_MAX) begin
			speech_gain = sample_t'(SAMPLE_MAX);
		end else if (boosted < SAMPLE_MIN) begin
			speech_gain = sample_t'(SAMPLE_MIN);
		end else begin
			speech_gain = boosted[SAMPLE_W-1:0];
		end
	end

	// Back to offset binary
	// raw speech is already unsigned
	assign speech_term = speech_filter_en ? speech_gain + 16'h8000 : speech_in;
	assign dac_term    = dac_filt + 16'h8000;
	assign mix_sum     = {1'b0, dac_term} + {1'b0, speech_term};

	// Raw speech and mode are sampled together with the filtered result
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_out    <= '0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= done;
			if (done) begin
				audio_out <= mix_sum[SAMPLE_W:1];
			end
		end
	end

endmodule

// File: audio_top.sv
/*
 * Audio back end top level
 * Boxcar and low-pass for the sound DAC, two-stage speech filter,
 * and the mix into one 16-bit unsigned output
 */
`timescale 1ns/1ps

module audio_top (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic [audio_pkg::DAC_W-1:0]    dac_in,
	input  logic [audio_pkg::SAMPLE_W-1:0] speech_in,
	input  logic                        speech_filter_en,
	output logic [audio_pkg::SAMPLE_W-1:0] audio_out,
	output logic                        sample_valid
);
	import audio_pkg::*;

	logic               tick;
	logic [DAC_W-1:0]   dac_avg;
	section_t           section;
	logic [2:0]         tap;
	logic               acc_clear;
	logic               acc_en;
	logic               write_en;
	logic               done;
	sample_t            dac_filt;
	sample_t            speech_filt;

	// Sample rate strobe
	sample_timer u_timer (
		.clk_sys (clk_sys),
		.reset   (reset),
		.tick    (tick)
	);

	dac_boxcar u_boxcar (
		.clk_sys (clk_sys),
		.reset   (reset),
		.tick    (tick),
		.dac_in  (dac_in),
		.dac_avg (dac_avg)
	);

	// Control and shared MAC for all three sections
	filter_sequencer u_seq (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.tick      (tick),
		.section   (section),
		.tap       (tap),
		.acc_clear (acc_clear),
		.acc_en    (acc_en),
		.write_en  (write_en),
		.done      (done)
	);

	filter_datapath u_datapath (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dac_avg     (dac_avg),
		.speech_in   (speech_in),
		.tick        (tick),
		.section     (section),
		.tap         (tap),
		.acc_clear   (acc_clear),
		.acc_en      (acc_en),
		.write_en    (write_en),
		.dac_filt    (dac_filt),
		.speech_filt (speech_filt)
	);

	audio_mixer u_mixer (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.done             (done),
		.speech_in        (speech_in),
		.speech_filter_en (speech_filter_en),
		.dac_filt         (dac_filt),
		.speech_filt      (speech_filt),
		.audio_out        (audio_out),
		.sample_valid     (sample_valid)
	);

endmodule

// File: audio_assertions.sv
/*
 * Audio back end assertions
 * Tick spacing, filter pass latency and output hold between samples
 */
`timescale 1ns/1ps

module audio_assertions (
	input logic        clk_sys,
	input logic        reset,
	input logic        tick,
	input logic        sample_valid,
	input logic [15:0] audio_out
);
	import audio_pkg::*;

	// Clocks since the last tick or since reset
	logic [DIV_BITS:0] since_tick;
	// Number of assertion failures so far
	int fail_count = 0;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			since_tick <= (DIV_BITS+1)'(1);
		end else if (tick) begin
			since_tick <= (DIV_BITS+1)'(1);
		end else begin
			since_tick <= since_tick + 1'b1;
		end
	end

	tick_on_time: assert property (@(posedge clk_sys) disable iff (reset)
		tick |-> since_tick == (DIV_BITS+1)'(SAMPLE_DIV))
		else begin
			fail_count++;
			$error("tick came early, after %0d clocks", since_tick);
		end

	tick_not_missing: assert property (@(posedge clk_sys) disable iff (reset)
		since_tick <= (DIV_BITS+1)'(SAMPLE_DIV))
		else begin
			fail_count++;
			$error("no tick within %0d clocks", SAMPLE_DIV);
		end

	// Sequencer pass plus mixer register
	valid_latency: assert property (@(posedge clk_sys) disable iff (reset)
		sample_valid |-> $past(tick, 18))
		else begin
			fail_count++;
			$error("sample_valid not 18 clocks after tick");
		end

	out_hold: assert property (@(posedge clk_sys) disable iff (reset)
		!sample_valid |-> $stable(audio_out))
		else begin
			fail_count++;
			$error("audio_out changed without sample_valid");
		end

endmodule

// File: tb_audio_top.sv
/*
 * Audio back end testbench
 * Table of DAC and speech levels applied per sample period, each
 * sample checked against a cycle-level model of boxcar, filters and mixer
 */
`timescale 1ns/1ps

module tb_audio_top;
	import audio_pkg::*;

	localparam int NUM_ROWS  = 13;
	localparam int NUM_FIXED = 7;
	// Reset, drain after the last tick and some slack
	localparam int MARGIN    = 5 + 24 + 64;

	logic        clk_sys;
	logic        reset;
	logic [7:0]  dac_in;
	logic [15:0] speech_in;
	logic        speech_filter_en;
	logic [15:0] audio_out;
	logic        sample_valid;

	// Stimulus table with one row per test
	string       row_name [NUM_ROWS];
	logic [7:0]  row_dac [NUM_ROWS];
	logic [15:0] row_speech [NUM_ROWS];
	logic        row_en [NUM_ROWS];
	int          row_periods [NUM_ROWS];
	int          row_settle [NUM_ROWS];
	int          row_checks [NUM_ROWS];
	int          row_errors [NUM_ROWS];

	int          period_row [$];
	logic [15:0] exp_out [$];
	int          exp_row [$];

	int          checks;
	int          errors;
	int          samples;
	int          total_periods;
	int          cycle_limit;
	int          edge_cnt;
	int          last_valid;
	logic [31:0] lfsr;

	// Model history per section in DAC, speech 1, speech 2 order
	int hx1 [3];
	int hx2 [3];
	int hy1 [3];
	int hy2 [3];
	int m_count;
	int m_boxcar;
	int m_mix_wait;
	int m_row;

	audio_top dut (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.dac_in           (dac_in),
		.speech_in        (speech_in),
		.speech_filter_en (speech_filter_en),
		.audio_out        (audio_out),
		.sample_valid     (sample_valid)
	);

	bind audio_top audio_assertions u_assertions (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.tick         (tick),
		.sample_valid (sample_valid),
		.audio_out    (audio_out)
	);

	// 100 ns period
	always #50 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic int clamp16(input longint v);
		if (v > 32767)
			return 32767;
		if (v < -32768)
			return -32768;
		return int'(v);
	endfunction

	// Direct form I, full precision sum, Q15 scale, saturate
	function automatic int filter_step(input int x, input int x1, input int x2,
		input int y1, input int y2, input int b1, input int b2, input int b3,
		input int a2, input int a3);
		longint sum;
		sum = longint'(b1) * x + longint'(b2) * x1 + longint'(b3) * x2;
		sum = sum - longint'(a2) * y1 - longint'(a3) * y2;
		return clamp16(sum >>> COEFF_SCALE);
	endfunction

	function automatic logic [15:0] mix_model(input int dac_y, input int sp_y,
		input logic [15:0] raw, input logic en);
		int sp_term;
		int dac_term;
		// Speech gain of four and back to offset binary
		sp_term  = en ? clamp16(longint'(sp_y) * 4) + 32768 : int'(raw);
		dac_term = dac_y + 32768;
		return 16'((dac_term + sp_term) >> 1);
	endfunction

	task automatic push_history(input int s, input int x, input int y);
		hx2[s] = hx1[s];
		hx1[s] = x;
		hy2[s] = hy1[s];
		hy1[s] = y;
	endtask

	// Tick every 256 edges and mix 17 edges after it
	always @(posedge clk_sys) begin : model
		int x;
		int y;
		if (reset) begin
			m_count    = 0;
			m_boxcar   = 0;
			m_mix_wait = 0;
			for (int i = 0; i < 3; i++) begin
				hx1[i] = 0;
				hx2[i] = 0;
				hy1[i] = 0;
				hy2[i] = 0;
			end
		end else begin
			if (m_mix_wait > 0) begin
				m_mix_wait--;
				if (m_mix_wait == 0) begin
					exp_out.push_back(mix_model(hy1[0], hy1[2], speech_in, speech_filter_en));
					exp_row.push_back(m_row);
				end
			end
			m_count++;
			if (m_count == SAMPLE_DIV) begin
				// Boxcar mean includes this edge's sample
				x = ((m_boxcar + int'(dac_in)) / SAMPLE_DIV) * 256 - 32768;
				m_count  = 0;
				m_boxcar = 0;
				m_row    = period_row.pop_front();
				y = filter_step(x, hx1[0], 0, hy1[0], 0, DAC_B1, DAC_B2, 0, DAC_A2, 0);
				push_history(0, x, y);
				x = int'(speech_in) - 32768;
				y = filter_step(x, hx1[1], hx2[1], hy1[1], hy2[1],
					SP1_B1, SP1_B2, SP1_B3, SP1_A2, SP1_A3);
				push_history(1, x, y);
				x = y;
				y = filter_step(x, hx1[2], hx2[2], hy1[2], hy2[2],
					SP2_B1, SP2_B2, SP2_B3, SP2_A2, SP2_A3);
				push_history(2, x, y);
				m_mix_wait = 17;
			end else begin
				m_boxcar += int'(dac_in);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers and checks
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic set_row(input int i, input string name, input logic [7:0] d,
		input logic [15:0] s, input logic en, input int n, input int settle);
		row_name[i]    = name;
		row_dac[i]     = d;
		row_speech[i]  = s;
		row_en[i]      = en;
		row_periods[i] = n;
		row_settle[i]  = settle;
		row_checks[i]  = 0;
		row_errors[i]  = 0;
	endtask

	task automatic build_table();
		logic [31:0] d;
		logic [31:0] s;
		logic [31:0] e;
		logic [31:0] n;
		set_row(0, "midscale", 8'd128, 16'h8000, 1'b1, 10, 32'h8000);
		set_row(1, "dac step low", 8'd0, 16'h8000, 1'b1, 6, -1);
		set_row(2, "dac step high", 8'd255, 16'h8000, 1'b1, 10, -1);
		set_row(3, "speech full scale", 8'd128, 16'hFFFF, 1'b1, 14, -1);
		set_row(4, "speech zero", 8'd128, 16'h0000, 1'b1, 10, -1);
		set_row(5, "raw speech", 8'd64, 16'h1234, 1'b0, 6, -1);
		set_row(6, "raw speech high", 8'd200, 16'hC000, 1'b0, 6, -1);
		// Random rows switch the speech mode too
		for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
			draw_bits(8, d);
			draw_bits(16, s);
			draw_bits(1, e);
			draw_bits(2, n);
			set_row(i, "random", d[7:0], s[15:0], e[0], 2 + int'(n[1:0]), -1);
		end
	endtask

	task automatic apply_row(input int r);
		dac_in           <= row_dac[r];
		speech_in        <= row_speech[r];
		speech_filter_en <= row_en[r];
		period_row.push_back(r);
	endtask

	task automatic check_equal(input logic [15:0] got, input logic [15:0] exp,
		input string what, output bit ok);
		checks++;
		ok = (got === exp);
		if (!ok) begin
			errors++;
			$display("ERR %0t ns: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_reset_state();
		bit ok_out;
		bit ok_valid;
		@(negedge clk_sys);
		check_equal(audio_out, 16'h0000, "audio_out after reset", ok_out);
		check_equal({15'd0, sample_valid}, 16'h0000, "sample_valid after reset", ok_valid);
		$display("test 0 reset: %s", (ok_out && ok_valid) ? "ok" : "mismatch");
	endtask

	// Compares each output sample, spacing and run length
	always @(posedge clk_sys) begin : monitor
		int r;
		logic [15:0] e;
		bit ok_val;
		bit ok_gap;
		bit ok_lvl;
		edge_cnt++;
		if (cycle_limit > 0 && edge_cnt >= cycle_limit) begin
			$display("timeout: run still going after %0d cycles", edge_cnt);
			$display("CHECKS FAILED");
			$finish;
		end else if (sample_valid) begin
			if (exp_out.size() == 0) begin
				$display("sample_valid at %0t ns with no sample expected by the model", $time);
				errors++;
			end else begin
				e = exp_out.pop_front();
				r = exp_row.pop_front();
				check_equal(audio_out, e, {"audio_out in ", row_name[r]}, ok_val);
				if (samples > 0) begin
					check_equal(16'(edge_cnt - last_valid), 16'(SAMPLE_DIV),
						"sample_valid spacing", ok_gap);
					ok_val = ok_val && ok_gap;
				end
				row_checks[r]++;
				if (!ok_val)
					row_errors[r]++;
				if (row_checks[r] == row_periods[r]) begin
					if (row_settle[r] >= 0) begin
						check_equal(audio_out, 16'(row_settle[r]), "settled level", ok_lvl);
						if (!ok_lvl)
							row_errors[r]++;
					end
					$display("test %0d %s: %0d samples, %0d errors", r + 1, row_name[r],
						row_checks[r], row_errors[r]);
				end
			end
			samples++;
			last_valid = edge_cnt;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		clk_sys          = 1'b0;
		reset            = 1'b1;
		dac_in           = 8'd0;
		speech_in        = 16'h8000;
		speech_filter_en = 1'b1;
		lfsr             = 32'h983a8e43;
		checks           = 0;
		errors           = 0;
		samples          = 0;
		edge_cnt         = 0;
		last_valid       = 0;
		total_periods    = 0;
		build_table();
		for (int r = 0; r < NUM_ROWS; r++)
			total_periods += row_periods[r];
		cycle_limit = total_periods * SAMPLE_DIV + MARGIN;

		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		// Inputs change on tick edges so each period sees one row
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int p = 0; p < row_periods[r]; p++) begin
				apply_row(r);
				if (r == 0 && p == 0)
					check_reset_state();
				repeat (SAMPLE_DIV) @(posedge clk_sys);
			end
		end
		// Last sample leaves the mixer 18 clocks after the final tick
		repeat (24) @(posedge clk_sys);

		if (samples != total_periods || exp_out.size() != 0) begin
			$display("sample count wrong: got %0d output samples for %0d periods",
				samples, total_periods);
			errors++;
		end
		if (dut.u_assertions.fail_count != 0) begin
			$display("%0d assertion failures during the run", dut.u_assertions.fail_count);
			errors += dut.u_assertions.fail_count;
		end
		$display("checks %0d, errors %0d, samples %0d", checks, errors, samples);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: all.f
audio_pkg.sv
sample_timer.sv
dac_boxcar.sv
filter_sequencer.sv
filter_datapath.sv
audio_mixer.sv
audio_top.sv
audio_assertions.sv
tb_audio_top.sv

// File: Makefile
VERILATOR  ?= verilator
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_audio_top
FILELIST   = all.f
LOG        = sim.log
FAIL_MSG   = CHECKS FAILED
PASS_MSG   = ALL CHECKS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: build
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
